// File: source/mipsPkg.sv
package mipsPkg;

    localparam int wordW   = 32;                       // Data and address width
    localparam int regIdxW = 5;                        // Register index width
    localparam int opcodeW = 6;                        // Opcode field width
    localparam int functW  = 6;                        // Funct field width

    typedef logic [wordW-1:0]   word_t;                // One data or address word
    typedef logic [regIdxW-1:0] regIdx_t;              // One register index

    // Opcodes of the supported subset
    localparam logic [opcodeW-1:0] opRType = 6'b000000; // add, sub, and, or, slt
    localparam logic [opcodeW-1:0] opAddi  = 6'b001000;
    localparam logic [opcodeW-1:0] opLw    = 6'b100011;
    localparam logic [opcodeW-1:0] opSw    = 6'b101011;
    localparam logic [opcodeW-1:0] opBeq   = 6'b000100;
    localparam logic [opcodeW-1:0] opBne   = 6'b000101;
    localparam logic [opcodeW-1:0] opJ     = 6'b000010;

    // Funct codes for R-type
    localparam logic [functW-1:0] fnAdd = 6'b100000;
    localparam logic [functW-1:0] fnSub = 6'b100010;
    localparam logic [functW-1:0] fnAnd = 6'b100100;
    localparam logic [functW-1:0] fnOr  = 6'b100101;
    localparam logic [functW-1:0] fnSlt = 6'b101010;

    // ALU codes where bit 2 selects the inverted B operand
    typedef enum logic [2:0] {
        aluAnd = 3'b000,
        aluOr  = 3'b001,
        aluAdd = 3'b010,
        aluSub = 3'b110,
        aluSlt = 3'b111
    } aluOp_t;

    typedef struct packed {
        logic [opcodeW-1:0] opcode;
        regIdx_t            rs;                        // First source
        regIdx_t            rt;                        // Second source
        regIdx_t            rd;                        // Destination
        logic [4:0]         shamt;                     // Unused by this subset
        logic [functW-1:0]  funct;
    } rFields_t;

    typedef struct packed {
        logic [opcodeW-1:0] opcode;
        regIdx_t            rs;                        // Base or first source
        regIdx_t            rt;                        // Destination or store data
        logic [15:0]        imm;                       // Signed immediate
    } iFields_t;

    typedef struct packed {
        logic [opcodeW-1:0] opcode;
        logic [25:0]        target;                    // Word index within region
    } jFields_t;

    // One instruction word seen three ways
    typedef union packed {
        rFields_t r;
        iFields_t i;
        jFields_t j;
    } instr_u;

    typedef struct packed {
        logic    useImm;                               // B operand is sign-extended imm
        logic    memRead;
        logic    memWrite;
        logic    memToReg;                             // Writeback from data memory
        logic    regWrite;
        logic    beq;
        logic    bne;
        logic    jump;
        aluOp_t  aluOp;
        regIdx_t dest;                                 // rd for R-type, rt otherwise
    } ctrl_t;

    typedef struct packed {
        logic    en;
        regIdx_t addr;
        word_t   data;
    } wb_t;

    typedef struct packed {
        word_t addr;                                   // Byte address
        word_t wdata;
        logic  read;
        logic  write;
    } dmemReq_t;

endpackage

// File: source/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder import mipsPkg::*; (
    input  instr_u instr,
    output ctrl_t  ctrl
);

    aluOp_t fnOp;                                      // ALU op from funct
    logic   fnValid;                                   // Funct is one we support

    // R-type funct lookup
    always_comb begin
        fnValid = 1'b1;
        fnOp    = aluAdd;
        case (instr.r.funct)
            fnAdd:   fnOp = aluAdd;
            fnSub:   fnOp = aluSub;
            fnAnd:   fnOp = aluAnd;
            fnOr:    fnOp = aluOr;
            fnSlt:   fnOp = aluSlt;
            default: fnValid = 1'b0;                   // Unknown funct leaves regWrite low
        endcase
    end

    always_comb begin
        ctrl       = '0;                               // All enables off by default
        ctrl.aluOp = aluAdd;
        ctrl.dest  = instr.i.rt;                       // I-type writes rt
        case (instr.r.opcode)
            opRType: begin
                ctrl.dest     = instr.r.rd;
                ctrl.aluOp    = fnOp;
                ctrl.regWrite = fnValid;
            end
            opAddi: begin
                ctrl.useImm   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opLw: begin
                ctrl.useImm   = 1'b1;                  // Address is base plus offset
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            opSw: begin
                ctrl.useImm   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            opBeq: begin
                ctrl.beq   = 1'b1;
                ctrl.aluOp = aluSub;                   // Compare by subtraction
            end
            opBne: begin
                ctrl.bne   = 1'b1;
                ctrl.aluOp = aluSub;
            end
            opJ:     ctrl.jump = 1'b1;
            default: ;                                 // Undefined opcode only advances the PC
        endcase
    end

endmodule

// File: source/registerFile.sv
`timescale 1ns/1ns

module registerFile import mipsPkg::*; (
    input  logic    Clk,
    input  regIdx_t rsAddr,
    input  regIdx_t rtAddr,
    input  wb_t     wb,                                // Write port
    output word_t   rsData,
    output word_t   rtData
);

    word_t regs [2**regIdxW];                          // Entry 0 is never written

    // Write on the edge that ends the instruction
    always_ff @(posedge Clk) begin
        if (wb.en && (wb.addr != '0)) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // Asynchronous reads with $zero forced
    always_comb begin
        if (rsAddr == '0) begin
            rsData = '0;
        end else begin
            rsData = regs[rsAddr];
        end
    end

    always_comb begin
        if (rtAddr == '0) begin
            rtData = '0;
        end else begin
            rtData = regs[rtAddr];
        end
    end

endmodule

// File: source/executeUnit.sv
`timescale 1ns/1ns

module executeUnit import mipsPkg::*; (
    input  logic     Clk,
    input  logic     rst,
    input  instr_u   instr,
    input  ctrl_t    ctrl,
    input  word_t    rsData,
    input  word_t    rtData,
    input  word_t    memRData,                         // Load data in the same cycle
    output word_t    instrAddr,
    output dmemReq_t dmemReq,
    output wb_t      wb
);

    word_t pc;                                         // Program counter
    word_t nextPc;
    word_t pcPlus4;
    word_t immExt;                                     // Sign-extended immediate
    word_t opB;                                        // ALU operand B
    word_t aluResult;
    logic  aluZero;                                    // Operands equal on sub
    logic  branchTaken;
    word_t branchTarget;
    word_t jumpTarget;

    assign instrAddr = pc;

    always_ff @(posedge Clk) begin
        if (rst) begin
            pc <= '0;                                  // Fetch starts at address 0
        end else begin
            pc <= nextPc;
        end
    end

    assign pcPlus4 = pc + word_t'(4);
    assign immExt  = {{(wordW-16){instr.i.imm[15]}}, instr.i.imm};
    assign opB     = ctrl.useImm ? immExt : rtData;    // I-type uses immediate

    // Behavioral ALU on the 3-bit codes
    always_comb begin
        case (ctrl.aluOp)
            aluAnd:  aluResult = rsData & opB;
            aluOr:   aluResult = rsData | opB;
            aluAdd:  aluResult = rsData + opB;
            aluSub:  aluResult = rsData - opB;
            aluSlt:  aluResult = {{(wordW-1){1'b0}}, $signed(rsData) < $signed(opB)};
            default: aluResult = '0;
        endcase
    end

    assign aluZero = (aluResult == '0);

    // beq and bne share the sub result
    assign branchTaken  = (ctrl.beq && aluZero) || (ctrl.bne && !aluZero);
    assign branchTarget = pcPlus4 + {immExt[wordW-3:0], 2'b00};
    assign jumpTarget   = {pcPlus4[wordW-1:wordW-4], instr.j.target, 2'b00};

    always_comb begin
        if (ctrl.jump) begin
            nextPc = jumpTarget;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;                          // Also for undefined codes
        end
    end

    // Data memory request addressed by the ALU sum
    always_comb begin
        dmemReq.addr  = aluResult;
        dmemReq.wdata = rtData;                        // Store data is rt
        dmemReq.read  = ctrl.memRead;
        dmemReq.write = ctrl.memWrite && !rst;         // No stores during reset
    end

    // Writeback select
    always_comb begin
        wb.en   = ctrl.regWrite && !rst;
        wb.addr = ctrl.dest;
        if (ctrl.memToReg) begin
            wb.data = memRData;                        // lw result
        end else begin
            wb.data = aluResult;
        end
    end

endmodule

// File: source/mipsCore.sv
`timescale 1ns/1ns

module mipsCore import mipsPkg::*; (
    input  logic     Clk,
    input  logic     rst,
    input  instr_u   instr,                            // Fetched word for instrAddr
    input  word_t    memRData,                         // Data memory read in the same cycle
    output word_t    instrAddr,                        // PC as a byte address
    output dmemReq_t dmemReq,
    output wb_t      retire                            // Register write of this instruction
);

    ctrl_t ctrl;                                       // Decoded control bundle
    word_t rsData;
    word_t rtData;
    wb_t   wb;                                         // Writeback into the register file

    instrDecoder uDecoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    // Reads in parallel with decode
    registerFile uRegs (
        .Clk    (Clk),
        .rsAddr (instr.r.rs),
        .rtAddr (instr.r.rt),
        .wb     (wb),
        .rsData (rsData),
        .rtData (rtData)
    );

    executeUnit uExec (
        .Clk       (Clk),
        .rst       (rst),
        .instr     (instr),
        .ctrl      (ctrl),
        .rsData    (rsData),
        .rtData    (rtData),
        .memRData  (memRData),
        .instrAddr (instrAddr),
        .dmemReq   (dmemReq),
        .wb        (wb)
    );

    assign retire = wb;                                // Trace of the writeback

endmodule

// File: tb/mipsCore_properties.sv
`timescale 1ns/1ns

module mipsCore_properties import mipsPkg::*; (
    input logic     Clk,
    input logic     rst,
    input word_t    instrAddr,
    input dmemReq_t dmemReq,
    input wb_t      retire
);

    // Fetch address always on a word boundary
    aAligned: assert property (@(posedge Clk) disable iff (rst) instrAddr[1:0] == 2'b00)
        else $error("instrAddr is not word aligned");

    // First fetch after reset
    aStartAtZero: assert property (@(posedge Clk) $fell(rst) |-> instrAddr == '0)
        else $error("instrAddr is not zero after reset");

    // No instruction both stores and writes a register
    aOneWrite: assert property (@(posedge Clk) !(dmemReq.write && retire.en))
        else $error("store and register write in the same cycle");

    aQuietReset: assert property (@(posedge Clk) rst |-> !dmemReq.write && !retire.en)
        else $error("write enable active during reset");

endmodule

// File: tb/mipsCoreTb.sv
`timescale 1ns/1ns

module mipsCoreTb import mipsPkg::*; ();

    localparam int clkPeriod   = 10;                     // ns
    localparam int resetCycles = 5;
    localparam int nSteps      = 60;                     // Instructions checked including the halt loop
    localparam int memWords    = 64;

    typedef struct packed {
        wb_t      wb;
        dmemReq_t req;
        word_t    nextPc;
    } step_t;                                            // Expected result of one instruction

    logic     Clk;
    logic     rst;
    instr_u   instr;
    word_t    memRData;
    word_t    instrAddr;
    dmemReq_t dmemReq;
    wb_t      retire;

    word_t imem [memWords];
    word_t dmem [memWords];                              // Data memory seen by the DUT
    word_t refMem [memWords];                            // Architectural copy
    word_t refRegs [32];
    word_t refPc;
    word_t lcgState;
    step_t expStep;
    int    stepCount;
    int    pos;                                          // Next free program word

    mipsCore DUT (.Clk(Clk), .rst(rst), .instr(instr), .memRData(memRData),
        .instrAddr(instrAddr), .dmemReq(dmemReq), .retire(retire));

    bind mipsCore mipsCore_properties uProps (.Clk(Clk), .rst(rst),
        .instrAddr(instrAddr), .dmemReq(dmemReq), .retire(retire));

    always #(clkPeriod / 2) Clk = ~Clk;

    assign instr    = imem[instrAddr[7:2]];              // Combinational fetch
    assign memRData = dmem[dmemReq.addr[7:2]];

    always @(posedge Clk) begin
        if (rst) begin
            for (int k = 0; k < memWords; k++) dmem[k] <= fillWord(k); // Load pattern in reset
        end else if (dmemReq.write) begin
            dmem[dmemReq.addr[7:2]] <= dmemReq.wdata;
        end
    end

    function automatic word_t fillWord(int idx);
        return (word_t'(idx) * 32'h9E37_79B9) ^ 32'h5A5A_C3C3;
    endfunction

    function automatic word_t nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic word_t encR(regIdx_t rs, regIdx_t rt, regIdx_t rd, logic [5:0] fn);
        return {opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t encI(logic [5:0] op, regIdx_t rs, regIdx_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t encJ(logic [25:0] target);
        return {opJ, target};
    endfunction

    function automatic logic [5:0] pickFunct(int sel);
        case (sel)
            0:       return fnAdd;
            1:       return fnSub;
            2:       return fnAnd;
            3:       return fnOr;
            default: return fnSlt;
        endcase
    endfunction

    task automatic emit(word_t w);
        imem[pos] = w;
        pos++;
    endtask

    task automatic buildProgram();
        word_t      r;
        regIdx_t    rs;
        regIdx_t    rt;
        logic [5:0] op;
        for (int k = 0; k < memWords; k++) imem[k] = encJ(26'(k)); // Spare words loop on themselves
        pos = 0;
        for (int k = 1; k < 8; k++) begin
            r = nextRand();
            emit(encI(opAddi, 5'd0, regIdx_t'(k), r[15:0]));       // Random signed seeds
        end
        emit(encI(opAddi, 5'd0, 5'd8, 16'd64));                     // Store base
        r = nextRand();
        emit(encI(opAddi, 5'd0, 5'd0, r[15:0]));                    // Retires but $zero stays 0
        emit(encR(5'd0, 5'd1, 5'd9, fnOr));
        for (int k = 0; k < 12; k++) begin
            r = nextRand();
            emit(encR(regIdx_t'(r[18:16]), regIdx_t'(r[21:19]), regIdx_t'(r[24:22]),
                pickFunct(int'(r[31:28]) % 5)));
        end
        emit(encI(opSw, 5'd8, 5'd3, 16'hFFF8));                     // Negative offset to addr 56
        emit(encI(opLw, 5'd8, 5'd10, 16'hFFF8));
        emit(encI(opSw, 5'd0, 5'd5, 16'd12));
        emit(encI(opLw, 5'd0, 5'd11, 16'd12));
        emit(encI(opLw, 5'd0, 5'd12, 16'd100));                     // Untouched fill word
        r = nextRand();
        emit({6'b111111, r[25:0]});                                 // Undefined opcode
        emit(encR(5'd1, 5'd2, 5'd13, 6'b000111));                   // Undefined funct
        emit(encI(opBeq, 5'd1, 5'd1, 16'd1));                       // Taken and skips the next
        emit(encI(opAddi, 5'd0, 5'd14, 16'd1));
        emit(encI(opBne, 5'd1, 5'd1, 16'd1));                       // Not taken
        emit(encI(opAddi, 5'd0, 5'd14, 16'd2));
        for (int k = 0; k < 4; k++) begin
            r  = nextRand();
            rs = regIdx_t'(r[18:16]) + 5'd1;
            rt = r[19] ? rs : regIdx_t'(r[22:20]) + 5'd1;           // Sometimes equal operands
            op = r[23] ? opBeq : opBne;
            emit(encI(op, rs, rt, 16'd1));
            emit(encI(opAddi, 5'd0, 5'd14, 16'(k)));
        end
        emit(encI(opAddi, 5'd0, 5'd15, 16'd3));                     // Loop count
        emit(encI(opAddi, 5'd15, 5'd15, 16'hFFFF));
        emit(encI(opBne, 5'd15, 5'd0, 16'hFFFE));                   // Backward to the decrement
        emit(encJ(26'(pos + 2)));                                   // Skips one into the halt loop
        emit(encI(opAddi, 5'd0, 5'd16, 16'd7));
    endtask

    // Architectural model of one instruction
    function automatic step_t refStep(word_t pc, instr_u ins);
        step_t s;
        word_t a;
        word_t b;
        word_t imm;
        word_t pc4;
        s        = '0;
        pc4      = pc + 32'd4;
        s.nextPc = pc4;
        a        = refRegs[ins.r.rs];
        b        = refRegs[ins.r.rt];
        imm      = {{16{ins.i.imm[15]}}, ins.i.imm};
        case (ins.r.opcode)
            opRType: begin
                s.wb.en   = 1'b1;
                s.wb.addr = ins.r.rd;
                case (ins.r.funct)
                    fnAdd:   s.wb.data = a + b;
                    fnSub:   s.wb.data = a - b;
                    fnAnd:   s.wb.data = a & b;
                    fnOr:    s.wb.data = a | b;
                    fnSlt:   s.wb.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: s.wb.en = 1'b0;                        // Undefined funct writes nothing
                endcase
            end
            opAddi: s.wb = '{en: 1'b1, addr: ins.i.rt, data: a + imm};
            opLw: begin
                s.req.read = 1'b1;
                s.req.addr = a + imm;
                s.wb       = '{en: 1'b1, addr: ins.i.rt, data: refMem[s.req.addr[7:2]]};
            end
            opSw: begin
                s.req.write = 1'b1;
                s.req.addr  = a + imm;
                s.req.wdata = b;
            end
            opBeq:   if (a == b) s.nextPc = pc4 + {imm[29:0], 2'b00};
            opBne:   if (a != b) s.nextPc = pc4 + {imm[29:0], 2'b00};
            opJ:     s.nextPc = {pc4[31:28], ins.j.target, 2'b00};
            default: ;
        endcase
        return s;
    endfunction

    task automatic abortRun();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic checkWord(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Fail %s got %h expected %h at pc %h", name, got, exp, refPc);
            abortRun();
        end
    endtask

    task automatic checkWb(wb_t got, wb_t exp);
        checkWord("retire.en", word_t'(got.en), word_t'(exp.en));
        if (exp.en) begin                                           // Fields only matter on a write
            checkWord("retire.addr", word_t'(got.addr), word_t'(exp.addr));
            checkWord("retire.data", got.data, exp.data);
        end
    endtask

    task automatic checkDmem(dmemReq_t got, dmemReq_t exp);
        checkWord("dmemReq.read", word_t'(got.read), word_t'(exp.read));
        checkWord("dmemReq.write", word_t'(got.write), word_t'(exp.write));
        if (exp.read || exp.write) checkWord("dmemReq.addr", got.addr, exp.addr);
        if (exp.write) checkWord("dmemReq.wdata", got.wdata, exp.wdata);
    endtask

    // Compare before the edge commits state
    always @(posedge Clk) begin
        if (!rst) begin
            expStep = refStep(refPc, imem[refPc[7:2]]);
            checkWord("instrAddr", instrAddr, refPc);
            checkWb(retire, expStep.wb);
            checkDmem(dmemReq, expStep.req);
            if (expStep.wb.en && expStep.wb.addr != '0) begin
                refRegs[expStep.wb.addr] = expStep.wb.data;
            end
            if (expStep.req.write) refMem[expStep.req.addr[7:2]] = expStep.req.wdata;
            refPc = expStep.nextPc;
            stepCount++;
            if (stepCount == nSteps) begin
                $display("STATUS: PASS");
                $finish;
            end
        end
    end

    initial begin
        Clk       = 1'b0;
        rst       = 1'b1;
        lcgState  = 32'h3942_49ae;
        refPc     = '0;
        stepCount = 0;
        for (int k = 0; k < 32; k++) refRegs[k] = '0;
        for (int k = 0; k < memWords; k++) refMem[k] = fillWord(k);
        buildProgram();
        repeat (resetCycles) @(posedge Clk);
        @(negedge Clk);
        rst = 1'b0;                                                 // Release on falling edge
    end

    // Watchdog
    initial begin
        #((resetCycles + nSteps + 20) * clkPeriod);
        $display("Timeout: the core did not get through %0d instructions in time", nSteps);
        abortRun();
    end

endmodule

// File: mipsCore.f
source/mipsPkg.sv
source/instrDecoder.sv
source/registerFile.sv
source/executeUnit.sv
source/mipsCore.sv
tb/mipsCore_properties.sv
tb/mipsCoreTb.sv

// File: Makefile
TOP  = mipsCoreTb
MDIR = obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module mipsCore \
		source/mipsPkg.sv source/instrDecoder.sv source/registerFile.sv \
		source/executeUnit.sv source/mipsCore.sv
	verilator --lint-only --timing --assert --top-module $(TOP) -f mipsCore.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir $(MDIR) -f mipsCore.f
	./$(MDIR)/V$(TOP)

clean:
	rm -rf $(MDIR)
